// File: Bender.yml
package:
  name: ifu

sources:
  - src/ifu_pkg.sv
  - src/fetch_pair_if.sv
  - src/issue_pair_if.sv
  - src/wb_fetch_unit.sv
  - src/inst_fifo.sv
  - src/issue_ctrl.sv
  - src/ifu_top.sv
  - target: test
    files:
      - verif/wb_inst_mem.sv
      - verif/ifu_tb.sv

// File: all.f
src/ifu_pkg.sv
src/fetch_pair_if.sv
src/issue_pair_if.sv
src/wb_fetch_unit.sv
src/inst_fifo.sv
src/issue_ctrl.sv
src/ifu_top.sv
verif/wb_inst_mem.sv
verif/ifu_tb.sv

// File: src/fetch_pair_if.sv
`timescale 1ns/1ps
`default_nettype none

interface fetch_pair_if import ifu_pkg::*; ();

    // write strobes, en2 only ever with en1
    logic  wr_en1;
    logic  wr_en2;

    // older word goes in slot 1
    word_t wr_pc1;
    word_t wr_pc2;
    word_t wr_inst1;
    word_t wr_inst2;

    modport producer (
        output wr_en1,
        output wr_en2,
        output wr_pc1,
        output wr_pc2,
        output wr_inst1,
        output wr_inst2
    );

    modport consumer (
        input wr_en1,
        input wr_en2,
        input wr_pc1,
        input wr_pc2,
        input wr_inst1,
        input wr_inst2
    );

endinterface

`default_nettype wire

// File: src/ifu_pkg.sv
`default_nettype none

package ifu_pkg;

    // one instruction or one byte address
    typedef logic [31:0] word_t;

    // primary opcodes the front end cares about
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        REGIMM  = 6'h01,
        J       = 6'h02,
        JAL     = 6'h03,
        BEQ     = 6'h04,
        BNE     = 6'h05,
        BLEZ    = 6'h06,
        BGTZ    = 6'h07
    } op_e;

    // same 32 bits seen as register format or immediate format
    typedef union packed {
        struct packed {
            op_e        opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } r_fmt;
        struct packed {
            op_e         opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } i_fmt;
    } instr_u;

    // register jumps under SPECIAL
    localparam logic [5:0] FUNCT_JR   = 6'h08;
    localparam logic [5:0] FUNCT_JALR = 6'h09;

    // rt codes of the REGIMM branches
    localparam logic [4:0] RT_BLTZ   = 5'h00;
    localparam logic [4:0] RT_BGEZ   = 5'h01;
    localparam logic [4:0] RT_BLTZAL = 5'h10;
    localparam logic [4:0] RT_BGEZAL = 5'h11;

    // first fetch address after reset
    localparam word_t RESET_PC = 32'h0000_0000;

endpackage

`default_nettype wire

// File: src/ifu_top.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_top import ifu_pkg::*; #(
    parameter int FIFO_DEPTH = 16
) (
    input  logic  clk,
    input  logic  fifo_rst,

    // wishbone classic master
    output logic  wb_cyc,
    output logic  wb_stb,
    output word_t wb_adr,
    input  word_t wb_dat_i,
    input  logic  wb_ack,

    // redirect handshake
    input  logic  redirect_valid,
    input  word_t redirect_pc,
    output logic  redirect_ready,

    // issue
    input  logic  issue_ready,
    output logic  issue_valid1,
    output logic  issue_valid2,
    output word_t issue_inst1,
    output word_t issue_inst2,
    output word_t issue_pc1,
    output word_t issue_pc2,
    output logic  issue_in_delay_slot
);

    logic flush;
    logic room;

    // redirect taken only when the queue can give up its contents
    assign flush = redirect_valid && redirect_ready;

    fetch_pair_if fetch_bus ();
    issue_pair_if issue_bus (.clk(clk));

    wb_fetch_unit u_fetch (
        .clk      (clk),
        .fifo_rst (fifo_rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_i (wb_dat_i),
        .wb_ack   (wb_ack),
        .flush    (flush),
        .flush_pc (redirect_pc),
        .room     (room),
        .fetch    (fetch_bus.producer)
    );

    inst_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_fifo (
        .clk            (clk),
        .fifo_rst       (fifo_rst),
        .flush          (flush),
        .redirect_ready (redirect_ready),
        .room           (room),
        .fetch          (fetch_bus.consumer),
        .issue          (issue_bus.queue)
    );

    issue_ctrl u_issue (
        .issue_ready         (issue_ready),
        .issue_valid1        (issue_valid1),
        .issue_valid2        (issue_valid2),
        .issue_inst1         (issue_inst1),
        .issue_inst2         (issue_inst2),
        .issue_pc1           (issue_pc1),
        .issue_pc2           (issue_pc2),
        .issue_in_delay_slot (issue_in_delay_slot),
        .issue               (issue_bus.issuer)
    );

endmodule

`default_nettype wire

// File: src/inst_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module inst_fifo import ifu_pkg::*; #(
    // power of two, at least 4
    parameter int FIFO_DEPTH = 16
) (
    input  logic clk,
    input  logic fifo_rst,
    input  logic flush,

    output logic redirect_ready,
    output logic room,

    fetch_pair_if.consumer fetch,
    issue_pair_if.queue    issue
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);
    localparam int CNT_W = PTR_W + 1;

    // ring storage
    word_t inst_mem [FIFO_DEPTH];
    word_t pc_mem   [FIFO_DEPTH];

    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;

    // delay slot kept across a flush
    logic  save_valid;
    word_t save_inst;
    word_t save_pc;

    // master issued last was a lone branch
    logic ds_q;

    logic [1:0]       push_n;
    logic [1:0]       pop_n;
    logic             ring_pop;
    logic             ds_d;
    logic             keep_save;
    logic [PTR_W-1:0] ds_ptr;
    logic             ds_in_ring;

    // saved word sits in front of the ring
    assign ring_pop = issue.rd_en1 && !save_valid;
    assign push_n   = fetch.wr_en1 ? (fetch.wr_en2 ? 2'd2 : 2'd1) : 2'd0;
    assign pop_n    = ring_pop ? (issue.rd_en2 ? 2'd2 : 2'd1) : 2'd0;

    // flag as it will stand after this edge
    assign ds_d = issue.rd_en1 ? (issue.master_cti && !issue.rd_en2) : ds_q;

    // where the pending delay slot lives after this edge's pops
    assign keep_save  = save_valid && !issue.rd_en1;
    assign ds_ptr     = rd_ptr + PTR_W'(pop_n);
    assign ds_in_ring = count > CNT_W'(pop_n);

    // no flush while a delay slot is owed but not yet fetched
    assign redirect_ready = !ds_d || keep_save || ds_in_ring;

    // two free entries for a whole pair
    assign room = count <= CNT_W'(FIFO_DEPTH - 2);

    // head view
    assign issue.head_inst1    = save_valid ? save_inst : inst_mem[rd_ptr];
    assign issue.head_pc1      = save_valid ? save_pc : pc_mem[rd_ptr];
    assign issue.head_inst2    = inst_mem[rd_ptr + PTR_W'(1)];
    assign issue.head_pc2      = pc_mem[rd_ptr + PTR_W'(1)];
    assign issue.in_delay_slot = ds_q;

    // saved word always goes alone
    always_comb begin
        if (save_valid) begin
            issue.avail = 2'd1;
        end else if (count >= CNT_W'(2)) begin
            issue.avail = 2'd2;
        end else begin
            issue.avail = count[1:0];
        end
    end

    // storage writes
    always_ff @(posedge clk) begin
        if (fetch.wr_en1) begin
            inst_mem[wr_ptr] <= fetch.wr_inst1;
            pc_mem[wr_ptr]   <= fetch.wr_pc1;
        end
        if (fetch.wr_en2) begin
            inst_mem[wr_ptr + PTR_W'(1)] <= fetch.wr_inst2;
            pc_mem[wr_ptr + PTR_W'(1)]   <= fetch.wr_pc2;
        end
    end

    // flush empties the ring pointers and count
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push_n);
            rd_ptr <= rd_ptr + PTR_W'(pop_n);
            count  <= count + CNT_W'(push_n) - CNT_W'(pop_n);
        end
    end

    // delay slot flag
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            ds_q <= 1'b0;
        end else begin
            ds_q <= ds_d;
        end
    end

    // save register control
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            save_valid <= 1'b0;
        end else if (flush) begin
            // owed delay slot survives the flush
            save_valid <= ds_d;
        end else if (save_valid && issue.rd_en1) begin
            save_valid <= 1'b0;
        end
    end

    // copy the delay slot out of the ring before it is cleared
    always_ff @(posedge clk) begin
        if (flush && ds_d && !keep_save) begin
            save_inst <= inst_mem[ds_ptr];
            save_pc   <= pc_mem[ds_ptr];
        end
    end

    a_count_bound : assert property (
        @(posedge clk) disable iff (fifo_rst)
        count <= CNT_W'(FIFO_DEPTH)
    );

    // issuer must respect avail
    a_no_empty_pop : assert property (
        @(posedge clk) disable iff (fifo_rst)
        issue.rd_en1 |-> issue.avail != 2'd0
    );

endmodule

`default_nettype wire

// File: src/issue_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module issue_ctrl import ifu_pkg::*; (
    // downstream takes up to two this cycle
    input  logic  issue_ready,

    output logic  issue_valid1,
    output logic  issue_valid2,
    output word_t issue_inst1,
    output word_t issue_inst2,
    output word_t issue_pc1,
    output word_t issue_pc2,
    output logic  issue_in_delay_slot,

    issue_pair_if.issuer issue
);

    instr_u master_word;
    instr_u slave_word;
    logic   master_cti;
    logic   slave_cti;
    logic   rd_en1;
    logic   rd_en2;

    // branch, jump or register jump
    function automatic logic is_cti(instr_u ins);
        logic cti;
        cti = 1'b0;
        case (ins.i_fmt.opcode)
            BEQ, BNE, BLEZ, BGTZ, J, JAL: begin
                cti = 1'b1;
            end
            REGIMM: begin
                // regimm branches picked by rt
                cti = ins.i_fmt.rt inside {RT_BLTZ, RT_BGEZ, RT_BLTZAL, RT_BGEZAL};
            end
            SPECIAL: begin
                // jr and jalr picked by funct
                cti = ins.r_fmt.funct inside {FUNCT_JR, FUNCT_JALR};
            end
            default: begin
                cti = 1'b0;
            end
        endcase
        return cti;
    endfunction

    assign master_word = instr_u'(issue.head_inst1);
    assign slave_word  = instr_u'(issue.head_inst2);
    assign master_cti  = is_cti(master_word);
    assign slave_cti   = is_cti(slave_word);

    // master goes whenever something is there
    assign rd_en1 = issue_ready && (issue.avail != 2'd0);
    // a branch never takes the slave slot
    // avail stays at 1 while the saved delay slot is at the head
    assign rd_en2 = rd_en1 && (issue.avail == 2'd2) && !slave_cti;

    assign issue.rd_en1     = rd_en1;
    assign issue.rd_en2     = rd_en2;
    assign issue.master_cti = master_cti;

    // outputs straight off the queue head
    assign issue_valid1        = rd_en1;
    assign issue_valid2        = rd_en2;
    assign issue_inst1         = issue.head_inst1;
    assign issue_inst2         = issue.head_inst2;
    assign issue_pc1           = issue.head_pc1;
    assign issue_pc2           = issue.head_pc2;
    assign issue_in_delay_slot = issue.in_delay_slot && rd_en1;

    a_slave_needs_master : assert property (
        @(posedge issue.clk)
        rd_en2 |-> rd_en1
    );

    // lone branch leaves the queue owing a delay slot
    a_lone_branch_marks_slot : assert property (
        @(posedge issue.clk)
        rd_en1 && master_cti && !rd_en2 |=> issue.in_delay_slot
    );

endmodule

`default_nettype wire

// File: src/issue_pair_if.sv
`timescale 1ns/1ps
`default_nettype none

interface issue_pair_if import ifu_pkg::*; (
    input logic clk
);

    // queue head, slot 1 is the older entry
    word_t      head_inst1;
    word_t      head_inst2;
    word_t      head_pc1;
    word_t      head_pc2;
    // readable entries, 0 to 2
    logic [1:0] avail;
    logic       in_delay_slot;

    // pop requests back from the issuer
    logic       rd_en1;
    logic       rd_en2;
    // master word is a branch or jump
    logic       master_cti;

    modport queue (
        output head_inst1, head_inst2, head_pc1, head_pc2,
        output avail, in_delay_slot,
        input  rd_en1, rd_en2, master_cti
    );

    modport issuer (
        input  clk,
        input  head_inst1, head_inst2, head_pc1, head_pc2,
        input  avail, in_delay_slot,
        output rd_en1, rd_en2, master_cti
    );

endinterface

`default_nettype wire

// File: src/wb_fetch_unit.sv
`timescale 1ns/1ps
`default_nettype none

module wb_fetch_unit import ifu_pkg::*; (
    input  logic  clk,
    input  logic  fifo_rst,

    // wishbone classic, read only
    output logic  wb_cyc,
    output logic  wb_stb,
    output word_t wb_adr,
    input  word_t wb_dat_i,
    input  logic  wb_ack,

    // redirect
    input  logic  flush,
    input  word_t flush_pc,

    // at least two free queue entries
    input  logic  room,

    fetch_pair_if.producer fetch
);

    logic  cyc_q;
    logic  stb_q;
    // address of the read in flight or the next one
    word_t pc_q;

    // first word of an aligned pair waits here
    logic  hold_valid;
    word_t hold_inst;

    logic  take;
    logic  odd_word;

    // an ack only counts for our own open cycle
    assign take     = stb_q && wb_ack && !flush;
    assign odd_word = pc_q[2];

    assign wb_cyc = cyc_q;
    assign wb_stb = stb_q;
    assign wb_adr = pc_q;

    // bus control and pc
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            cyc_q      <= 1'b0;
            stb_q      <= 1'b0;
            pc_q       <= RESET_PC;
            hold_valid <= 1'b0;
        end else if (flush) begin
            // abandon any open cycle and restart from the target
            cyc_q      <= 1'b0;
            stb_q      <= 1'b0;
            pc_q       <= {flush_pc[31:2], 2'b00};
            hold_valid <= 1'b0;
        end else if (stb_q) begin
            if (wb_ack) begin
                // end of transfer with one idle cycle after
                cyc_q      <= 1'b0;
                stb_q      <= 1'b0;
                pc_q       <= pc_q + 32'd4;
                hold_valid <= !odd_word;
            end
        end else if (room) begin
            // new read only with space for a full pair
            cyc_q <= 1'b1;
            stb_q <= 1'b1;
        end
    end

    // even word parks until its partner arrives
    always_ff @(posedge clk) begin
        if (take && !odd_word) begin
            hold_inst <= wb_dat_i;
        end
    end

    // odd word closes the pair
    // without a held word this is a lone write from an odd redirect
    assign fetch.wr_en1   = take && odd_word;
    assign fetch.wr_en2   = take && odd_word && hold_valid;
    assign fetch.wr_inst1 = hold_valid ? hold_inst : wb_dat_i;
    assign fetch.wr_pc1   = hold_valid ? {pc_q[31:3], 3'b000} : pc_q;
    assign fetch.wr_inst2 = wb_dat_i;
    assign fetch.wr_pc2   = pc_q;

    // classic bus rules seen from the master
    a_stb_has_cyc : assert property (
        @(posedge clk) disable iff (fifo_rst)
        wb_stb |-> wb_cyc
    );

endmodule

`default_nettype wire

// File: verif/ifu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module ifu_tb import ifu_pkg::*; ();

    localparam int FIFO_DEPTH  = 16;
    localparam int MEM_WORDS   = 1024;
    localparam int IDX_W       = $clog2(MEM_WORDS);
    localparam int RST_CYCLES  = 16;
    localparam int NUM_ISSUE   = 3000;
    // 20 cycles per instruction plus reset
    localparam int MAX_CYCLES  = NUM_ISSUE * 20 + RST_CYCLES;

    logic  clk;
    logic  fifo_rst;
    logic  wb_cyc;
    logic  wb_stb;
    word_t wb_adr;
    word_t wb_dat_i;
    logic  wb_ack;
    logic  redirect_valid;
    word_t redirect_pc;
    logic  redirect_ready;
    logic  issue_ready;
    logic  issue_valid1;
    logic  issue_valid2;
    word_t issue_inst1;
    word_t issue_inst2;
    word_t issue_pc1;
    word_t issue_pc2;
    logic  issue_in_delay_slot;

    // program order model
    word_t rng;
    word_t exp_pc;
    logic  ds_owed;
    logic  redirect_after_ds;
    word_t after_ds_pc;
    int    issued;
    int    cycles;

    // redirect generator
    int    redir_wait;
    logic  redir_active;
    logic  flush_seen;

    // first read after a flush
    logic  adr_pending;
    word_t adr_target;

    ifu_top #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) u_ifu_top (
        .clk                 (clk),
        .fifo_rst            (fifo_rst),
        .wb_cyc              (wb_cyc),
        .wb_stb              (wb_stb),
        .wb_adr              (wb_adr),
        .wb_dat_i            (wb_dat_i),
        .wb_ack              (wb_ack),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc),
        .redirect_ready      (redirect_ready),
        .issue_ready         (issue_ready),
        .issue_valid1        (issue_valid1),
        .issue_valid2        (issue_valid2),
        .issue_inst1         (issue_inst1),
        .issue_inst2         (issue_inst2),
        .issue_pc1           (issue_pc1),
        .issue_pc2           (issue_pc2),
        .issue_in_delay_slot (issue_in_delay_slot)
    );

    wb_inst_mem #(
        .MEM_WORDS (MEM_WORDS),
        .SEED      (32'h1925)
    ) u_mem (
        .clk      (clk),
        .fifo_rst (fifo_rst),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_adr   (wb_adr),
        .wb_dat_o (wb_dat_i),
        .wb_ack   (wb_ack)
    );

    always #4 clk = ~clk;

    function automatic word_t next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return {16'h0, rng[31:16]};
    endfunction

    task automatic abort_run(input string why);
        $display("%s at %0t", why, $time);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got %h expected %h", $time, name, got, exp);
            abort_run("wrong value");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("MISMATCH time=%0t %s got %b expected %b", $time, name, got, exp);
            abort_run("wrong value");
        end
    endtask

    // inputs change on the falling edge
    task automatic drive_inputs();
        issue_ready = (next_rand() % 4) != 0;
        if (flush_seen) begin
            redirect_valid = 1'b0;
            redir_active   = 1'b0;
            flush_seen     = 1'b0;
        end
        if (redir_wait > 0) begin
            redir_wait = redir_wait - 1;
            if (redir_wait == 0) begin
                // word aligned target inside the memory
                redirect_valid = 1'b1;
                redirect_pc    = word_t'(next_rand() % MEM_WORDS) << 2;
                redir_active   = 1'b1;
            end
        end
    endtask

    // outputs have settled, compare and step the model
    task automatic check_cycle();
        int   idx;
        logic cti1;
        if (wb_stb) begin
            check_bit("wb_cyc", wb_cyc, 1'b1);
            if (wb_adr[1:0] != 2'b00) begin
                abort_run("wishbone read address is not word aligned");
            end
            if (adr_pending) begin
                check_word("wb_adr", wb_adr, adr_target);
                adr_pending = 1'b0;
            end
        end
        if (issue_valid1 && !issue_ready) begin
            abort_run("instruction issued while issue_ready was low");
        end
        if (issue_valid2 && !issue_valid1) begin
            abort_run("slave slot issued without the master slot");
        end
        check_bit("issue_in_delay_slot", issue_in_delay_slot, issue_valid1 && ds_owed);
        if (issue_valid1) begin
            idx = int'(exp_pc[IDX_W+1:2]);
            check_word("issue_pc1", issue_pc1, exp_pc);
            check_word("issue_inst1", issue_inst1, u_mem.mem[idx]);
            cti1 = u_mem.cti[idx];
            // saved delay slot goes first, then the redirect target
            if (redirect_after_ds) begin
                exp_pc            = after_ds_pc;
                redirect_after_ds = 1'b0;
            end else begin
                exp_pc = exp_pc + 32'd4;
            end
            ds_owed = cti1 && !issue_valid2;
            issued  = issued + 1;
            if (cti1 && !redir_active && redir_wait == 0) begin
                redir_wait = 1 + int'(next_rand() % 3);
            end
        end
        if (issue_valid2) begin
            idx = int'(exp_pc[IDX_W+1:2]);
            check_word("issue_pc2", issue_pc2, exp_pc);
            check_word("issue_inst2", issue_inst2, u_mem.mem[idx]);
            if (u_mem.cti[idx]) begin
                abort_run("control transfer issued in the slave slot");
            end
            exp_pc = exp_pc + 32'd4;
            issued = issued + 1;
        end
        // flush takes effect at the coming edge
        if (redirect_valid && redirect_ready) begin
            flush_seen  = 1'b1;
            adr_pending = 1'b1;
            adr_target  = redirect_pc;
            if (ds_owed) begin
                redirect_after_ds = 1'b1;
                after_ds_pc       = redirect_pc;
            end else begin
                exp_pc            = redirect_pc;
                redirect_after_ds = 1'b0;
            end
        end
    endtask

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            abort_run("timeout, too few instructions issued");
        end
    end

    initial begin
        clk               = 1'b0;
        fifo_rst          = 1'b1;
        redirect_valid    = 1'b0;
        redirect_pc       = '0;
        issue_ready       = 1'b0;
        rng               = 32'h1925;
        exp_pc            = RESET_PC;
        ds_owed           = 1'b0;
        redirect_after_ds = 1'b0;
        after_ds_pc       = '0;
        issued            = 0;
        cycles            = 0;
        redir_wait        = 0;
        redir_active      = 1'b0;
        flush_seen        = 1'b0;
        adr_pending       = 1'b0;
        adr_target        = '0;
        repeat (RST_CYCLES) @(negedge clk);
        fifo_rst = 1'b0;
        #2;
        // state straight out of reset
        check_bit("issue_valid1", issue_valid1, 1'b0);
        check_bit("issue_valid2", issue_valid2, 1'b0);
        check_bit("wb_cyc", wb_cyc, 1'b0);
        check_bit("wb_stb", wb_stb, 1'b0);
        check_bit("redirect_ready", redirect_ready, 1'b1);
        while (issued < NUM_ISSUE) begin
            @(negedge clk);
            drive_inputs();
            #2;
            check_cycle();
        end
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: verif/wb_inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module wb_inst_mem import ifu_pkg::*; #(
    parameter int    MEM_WORDS = 1024,
    parameter word_t SEED      = 32'h1925
) (
    input  logic  clk,
    input  logic  fifo_rst,
    input  logic  wb_cyc,
    input  logic  wb_stb,
    input  word_t wb_adr,
    output word_t wb_dat_o,
    output logic  wb_ack
);

    localparam int IDX_W = $clog2(MEM_WORDS);

    // program image and a flag per word for branches and jumps
    word_t mem [MEM_WORDS];
    logic  cti [MEM_WORDS];

    word_t rng;
    logic  busy;
    int    waits;

    function automatic word_t next_rand();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return {16'h0, rng[31:16]};
    endfunction

    // build one word with about one in six a control transfer
    task automatic fill_word(input int i);
        word_t body;
        word_t pick;
        body = (next_rand() << 16) ^ next_rand();
        pick = next_rand();
        cti[i] = (pick % 6) == 0;
        if (cti[i]) begin
            case (next_rand() % 5)
                0: mem[i] = {BEQ, body[25:0]};
                1: mem[i] = {BNE, body[25:0]};
                2: mem[i] = {REGIMM, body[25:21], RT_BGEZ, body[15:0]};
                3: mem[i] = {J, body[25:0]};
                default: mem[i] = {SPECIAL, body[25:6], FUNCT_JR};
            endcase
        end else begin
            // opcodes 8 and up are never a branch here
            mem[i] = {6'(8 + (next_rand() % 56)), body[25:0]};
        end
    endtask

    initial begin
        rng      = SEED;
        busy     = 1'b0;
        waits    = 0;
        wb_ack   = 1'b0;
        wb_dat_o = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            fill_word(i);
        end
    end

    // answers on the falling edge with ack over exactly one rising edge
    always @(negedge clk) begin
        if (fifo_rst) begin
            wb_ack <= 1'b0;
            busy   = 1'b0;
        end else begin
            wb_ack <= 1'b0;
            if (wb_cyc && wb_stb && !wb_ack) begin
                if (!busy) begin
                    busy  = 1'b1;
                    waits = int'(next_rand() % 4);
                end
                if (waits == 0) begin
                    wb_ack   <= 1'b1;
                    wb_dat_o <= mem[wb_adr[IDX_W+1:2]];
                    busy     = 1'b0;
                end else begin
                    waits = waits - 1;
                end
            end else begin
                // abandoned or finished cycle
                busy = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire
